// ==== soc_pkg.sv ====
package soc_pkg;

	// Bus words
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Top address nibble picks the slave
	typedef logic [3:0] region_t;

	localparam region_t REGION_RAM   = 4'h1;
	localparam region_t REGION_DMA   = 4'h9;
	localparam region_t REGION_TIMER = 4'hA;

	// AXI response codes
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	//==================================================
	// Register offsets from address bits 3:2

	typedef enum logic [1:0] {
		DMA_SOURCE = 2'd0,
		DMA_DEST   = 2'd1,
		// Writing the count starts a copy
		DMA_COUNT  = 2'd2,
		// Bit 0 is busy
		DMA_STATUS = 2'd3
	} dma_reg_e;

	typedef enum logic [1:0] {
		// Read, or write to load the counter
		TIMER_COUNT   = 2'd0,
		TIMER_COMPARE = 2'd1,
		// Bit 0 is enable
		TIMER_CONTROL = 2'd2
	} timer_reg_e;

endpackage

// ==== soc_bus_if.sv ====
`timescale 1ns/1ns

interface soc_bus_if import soc_pkg::*; ();

	// Driven by the master and held until ready
	logic  request;
	logic  rw;         // high for a write
	addr_t address;
	data_t wdata;

	// Driven by the slave with a one-cycle ready pulse
	data_t rdata;
	logic  ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

// ==== bus_access.sv ====
`timescale 1ns/1ns

module bus_access import soc_pkg::*; (
	input  logic      i_clock,
	input  logic      i_reset,

	// AXI4-Lite write channels
	input  logic      i_awvalid,
	output logic      o_awready,
	input  addr_t     i_awaddr,
	input  logic      i_wvalid,
	output logic      o_wready,
	input  data_t     i_wdata,
	output logic      o_bvalid,
	input  logic      i_bready,
	output resp_t     o_bresp,

	// AXI4-Lite read channels
	input  logic      i_arvalid,
	output logic      o_arready,
	input  addr_t     i_araddr,
	output logic      o_rvalid,
	input  logic      i_rready,
	output data_t     o_rdata,
	output resp_t     o_rresp,

	// Internal bus
	soc_bus_if.slave  dma_master_bus,
	soc_bus_if.master ram_bus,
	soc_bus_if.master dma_reg_bus,
	soc_bus_if.master timer_bus
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SLAVE,
		S_RESP,
		S_DMA_ERR
	} state_e;

	state_e  state;
	logic    prefer_dma;

	// Transaction taken in idle
	addr_t   op_address;
	data_t   op_wdata;
	logic    op_write;
	logic    op_dma;
	resp_t   resp_q;
	data_t   rdata_q;

	logic    axi_read;
	logic    axi_write;
	logic    grant_axi;
	logic    grant_dma;
	addr_t   in_address;
	region_t op_region;
	logic    sel_ram;
	logic    sel_dma;
	logic    sel_timer;
	logic    slave_ready;
	data_t   slave_rdata;

	function automatic logic is_mapped(region_t region);
		return region == REGION_RAM || region == REGION_DMA || region == REGION_TIMER;
	endfunction

	//==================================================
	// Round-robin arbitration between AXI and DMA

	assign axi_read = i_arvalid;
	assign axi_write = i_awvalid && i_wvalid;

	always_comb begin
		grant_axi = 1'b0;
		grant_dma = 1'b0;
		if (state == S_IDLE) begin
			grant_axi = (axi_read || axi_write) && (!dma_master_bus.request || !prefer_dma);
			grant_dma = dma_master_bus.request && !grant_axi;
		end
	end

	// Read goes first when both arrive
	assign o_arready = grant_axi && axi_read;
	assign o_awready = grant_axi && !axi_read;
	assign o_wready = o_awready;

	assign in_address = grant_dma ? dma_master_bus.address : (axi_read ? i_araddr : i_awaddr);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			prefer_dma <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (grant_axi || grant_dma) begin
						prefer_dma <= grant_axi;
						if (is_mapped(in_address[31:28]))
							state <= S_SLAVE;
						else if (grant_dma)
							state <= S_DMA_ERR;
						else
							state <= S_RESP;
					end
				end
				S_SLAVE: begin
					if (slave_ready)
						state <= op_dma ? S_IDLE : S_RESP;
				end
				S_RESP: begin
					if ((o_bvalid && i_bready) || (o_rvalid && i_rready))
						state <= S_IDLE;
				end
				S_DMA_ERR: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (grant_axi || grant_dma) begin
			op_address <= in_address;
			op_dma <= grant_dma;
			op_write <= grant_dma ? dma_master_bus.rw : !axi_read;
			op_wdata <= grant_dma ? dma_master_bus.wdata : i_wdata;
			// Unmapped access keeps these
			resp_q <= RESP_DECERR;
			rdata_q <= '0;
		end else if (state == S_SLAVE && slave_ready) begin
			resp_q <= RESP_OKAY;
			rdata_q <= slave_rdata;
		end
	end

	//==================================================
	// Region decode and slave fan-out

	assign op_region = op_address[31:28];
	assign sel_ram = op_region == REGION_RAM;
	assign sel_dma = op_region == REGION_DMA;
	assign sel_timer = op_region == REGION_TIMER;

	assign ram_bus.request = state == S_SLAVE && sel_ram;
	assign ram_bus.rw = op_write;
	assign ram_bus.address = {4'h0, op_address[27:0]};
	assign ram_bus.wdata = op_wdata;

	assign dma_reg_bus.request = state == S_SLAVE && sel_dma;
	assign dma_reg_bus.rw = op_write;
	assign dma_reg_bus.address = {4'h0, op_address[27:0]};
	assign dma_reg_bus.wdata = op_wdata;

	assign timer_bus.request = state == S_SLAVE && sel_timer;
	assign timer_bus.rw = op_write;
	assign timer_bus.address = {4'h0, op_address[27:0]};
	assign timer_bus.wdata = op_wdata;

	assign slave_ready = (sel_ram && ram_bus.ready) || (sel_dma && dma_reg_bus.ready) ||
		(sel_timer && timer_bus.ready);

	always_comb begin
		if (sel_ram)
			slave_rdata = ram_bus.rdata;
		else if (sel_dma)
			slave_rdata = dma_reg_bus.rdata;
		else if (sel_timer)
			slave_rdata = timer_bus.rdata;
		else
			slave_rdata = '0;
	end

	// DMA gets its answer straight from the slave or zero on a bad region
	assign dma_master_bus.ready = op_dma &&
		((state == S_SLAVE && slave_ready) || state == S_DMA_ERR);
	assign dma_master_bus.rdata = slave_rdata;

	assign o_bvalid = state == S_RESP && op_write;
	assign o_rvalid = state == S_RESP && !op_write;
	assign o_bresp = resp_q;
	assign o_rresp = resp_q;
	assign o_rdata = rdata_q;

	// Response held until taken
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

	assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0({ram_bus.request, dma_reg_bus.request, timer_bus.request}));

endmodule

// ==== bram.sv ====
`timescale 1ns/1ns

module bram import soc_pkg::*; #(
	parameter int WORDS = 4096,
	parameter int LATENCY = 2
) (
	input logic      i_clock,
	soc_bus_if.slave bus
);

	localparam int INDEX_WIDTH = $clog2(WORDS);

	data_t memory [WORDS];
	data_t rdata_q;

	// One bit per cycle of the access in flight
	logic [LATENCY-1:0] valid_chain = '0;
	logic [INDEX_WIDTH-1:0] index;
	logic start;

	assign index = INDEX_WIDTH'(bus.address[31:2] % WORDS);

	// Request stays high through ready, so only start when nothing is in flight
	assign start = bus.request && !(|valid_chain);

	always_ff @(posedge i_clock) begin
		valid_chain <= valid_chain << 1;
		valid_chain[0] <= start;
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			if (bus.rw)
				memory[index] <= bus.wdata;
			else
				rdata_q <= memory[index];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = valid_chain[LATENCY-1];

	assert property (@(posedge i_clock) bus.ready |-> bus.request);

endmodule

// ==== dma.sv ====
`timescale 1ns/1ns

module dma import soc_pkg::*; (
	input logic       i_clock,
	input logic       i_reset,
	soc_bus_if.slave  regs,
	soc_bus_if.master mem
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WRITE
	} state_e;

	state_e   state;
	logic     mem_request;
	logic     ready_q;
	data_t    rdata_q;

	// Running addresses and words left
	data_t    source;
	data_t    dest;
	data_t    count;
	data_t    buffer;

	logic     busy;
	logic     reg_access;
	logic     start;
	dma_reg_e reg_sel;

	assign busy = state != S_IDLE;
	assign reg_sel = dma_reg_e'(regs.address[3:2]);
	assign reg_access = regs.request && !ready_q;
	assign start = reg_access && regs.rw && reg_sel == DMA_COUNT && !busy && regs.wdata != '0;

	//==================================================
	// Copy sequencer with one read and one write per word

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			mem_request <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= reg_access;
			case (state)
				S_IDLE: begin
					if (start)
						state <= S_READ;
				end
				S_READ: begin
					if (mem.ready) begin
						mem_request <= 1'b0;
						state <= S_WRITE;
					end else if (!mem_request) begin
						mem_request <= 1'b1;
					end
				end
				S_WRITE: begin
					if (mem.ready) begin
						mem_request <= 1'b0;
						state <= (count == 32'd1) ? S_IDLE : S_READ;
					end else if (!mem_request) begin
						mem_request <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (reg_access) begin
			case (reg_sel)
				DMA_SOURCE: rdata_q <= source;
				DMA_DEST:   rdata_q <= dest;
				DMA_COUNT:  rdata_q <= count;
				DMA_STATUS: rdata_q <= {31'b0, busy};
			endcase
		end
		// Registers are locked while a copy runs
		if (reg_access && regs.rw && !busy) begin
			case (reg_sel)
				DMA_SOURCE: source <= regs.wdata;
				DMA_DEST:   dest <= regs.wdata;
				DMA_COUNT:  count <= regs.wdata;
				default: ;
			endcase
		end
		if (state == S_READ && mem.ready)
			buffer <= mem.rdata;
		if (state == S_WRITE && mem.ready) begin
			source <= source + 32'd4;
			dest <= dest + 32'd4;
			count <= count - 32'd1;
		end
	end

	assign regs.ready = ready_q;
	assign regs.rdata = rdata_q;

	assign mem.request = mem_request;
	assign mem.rw = state == S_WRITE;
	assign mem.address = (state == S_WRITE) ? dest : source;
	assign mem.wdata = buffer;

	assert property (@(posedge i_clock) disable iff (i_reset) mem.request |-> count != '0);

endmodule

// ==== timer.sv ====
`timescale 1ns/1ns

module timer import soc_pkg::*; #(
	parameter int TICK_DIVIDER = 4
) (
	input logic      i_clock,
	input logic      i_reset,
	soc_bus_if.slave regs,
	output logic     o_interrupt
);

	localparam int PRESCALE_WIDTH = (TICK_DIVIDER > 1) ? $clog2(TICK_DIVIDER) : 1;

	logic [PRESCALE_WIDTH-1:0] prescale;
	data_t      count;
	data_t      compare;
	data_t      rdata_q;
	logic       enable;
	logic       ready_q;
	logic       reg_access;
	logic       tick;
	timer_reg_e reg_sel;

	assign reg_sel = timer_reg_e'(regs.address[3:2]);
	assign reg_access = regs.request && !ready_q;
	assign tick = enable && prescale == PRESCALE_WIDTH'(TICK_DIVIDER - 1);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ready_q <= 1'b0;
			enable <= 1'b0;
			prescale <= '0;
			count <= '0;
		end else begin
			ready_q <= reg_access;
			if (enable)
				prescale <= tick ? '0 : prescale + 1'b1;
			if (tick)
				count <= count + 32'd1;
			// A bus load wins over the tick
			if (reg_access && regs.rw) begin
				case (reg_sel)
					TIMER_COUNT: begin
						count <= regs.wdata;
						prescale <= '0;
					end
					TIMER_CONTROL: enable <= regs.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (reg_access && regs.rw && reg_sel == TIMER_COMPARE)
			compare <= regs.wdata;
		if (reg_access) begin
			case (reg_sel)
				TIMER_COUNT:   rdata_q <= count;
				TIMER_COMPARE: rdata_q <= compare;
				TIMER_CONTROL: rdata_q <= {31'b0, enable};
				default:       rdata_q <= '0;
			endcase
		end
	end

	assign regs.ready = ready_q;
	assign regs.rdata = rdata_q;

	// Level that stays up until compare moves past count
	assign o_interrupt = enable && (count >= compare);

endmodule

// ==== soc.sv ====
`timescale 1ns/1ns

module soc import soc_pkg::*; #(
	parameter int RAM_WORDS = 4096,
	parameter int RAM_LATENCY = 2,
	parameter int TICK_DIVIDER = 4
) (
	input  logic  i_clock,
	input  logic  i_reset,

	// AXI4-Lite slave port
	input  logic  i_awvalid,
	output logic  o_awready,
	input  addr_t i_awaddr,
	input  logic  i_wvalid,
	output logic  o_wready,
	input  data_t i_wdata,
	output logic  o_bvalid,
	input  logic  i_bready,
	output resp_t o_bresp,
	input  logic  i_arvalid,
	output logic  o_arready,
	input  addr_t i_araddr,
	output logic  o_rvalid,
	input  logic  i_rready,
	output data_t o_rdata,
	output resp_t o_rresp,

	output logic  o_timer_interrupt
);

	soc_bus_if dma_master_bus();
	soc_bus_if ram_bus();
	soc_bus_if dma_reg_bus();
	soc_bus_if timer_bus();

	//==================================================
	// Bus control

	bus_access bus(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.i_wdata(i_wdata),
		.o_bvalid(o_bvalid),
		.i_bready(i_bready),
		.o_bresp(o_bresp),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.i_araddr(i_araddr),
		.o_rvalid(o_rvalid),
		.i_rready(i_rready),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.dma_master_bus(dma_master_bus),
		.ram_bus(ram_bus),
		.dma_reg_bus(dma_reg_bus),
		.timer_bus(timer_bus)
	);

	//==================================================
	// Slaves

	bram #(
		.WORDS(RAM_WORDS),
		.LATENCY(RAM_LATENCY)
	) ram(
		.i_clock(i_clock),
		.bus(ram_bus)
	);

	dma dma_engine(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.regs(dma_reg_bus),
		.mem(dma_master_bus)
	);

	timer #(
		.TICK_DIVIDER(TICK_DIVIDER)
	) tick_timer(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.regs(timer_bus),
		.o_interrupt(o_timer_interrupt)
	);

endmodule

// ==== tb_soc_checks.svh ====
`ifndef TB_SOC_CHECKS_SVH
`define TB_SOC_CHECKS_SVH

//==================================================
// Failure reporting and compares

task automatic report_failure();
	$display("*** FAILED ***");
	$fatal(1, "Stopped at the first error");
endtask

task automatic check_data(string name, data_t actual, data_t expected);
	if (actual !== expected) begin
		$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		report_failure();
	end
endtask

task automatic check_resp(string name, resp_t actual, resp_t expected);
	if (actual !== expected) begin
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		report_failure();
	end
endtask

task automatic check_flag(string name, logic actual, logic expected);
	if (actual !== expected) begin
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		report_failure();
	end
endtask

// LCG with the usual 32-bit constants
function automatic data_t next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic addr_t reg_address(addr_t base, logic [1:0] offset);
	return base + {28'b0, offset, 2'b00};
endfunction

//==================================================
// AXI4-Lite driver

// Address and data handshake only
task automatic send_write(addr_t address, data_t data);
	@(negedge clock);
	awvalid = 1'b1;
	wvalid = 1'b1;
	awaddr = address;
	wdata = data;
	do begin
		@(posedge clock);
	end while (!awready);
	// Write data is taken in the same cycle as the address
	check_flag("o_wready", wready, 1'b1);
	@(negedge clock);
	awvalid = 1'b0;
	wvalid = 1'b0;
endtask

task automatic wait_write_response(output resp_t resp);
	do begin
		@(posedge clock);
	end while (!bvalid);
	resp = bresp;
endtask

task automatic send_read(addr_t address);
	@(negedge clock);
	arvalid = 1'b1;
	araddr = address;
	do begin
		@(posedge clock);
	end while (!arready);
	@(negedge clock);
	arvalid = 1'b0;
endtask

task automatic wait_read_response(output data_t data, output resp_t resp);
	do begin
		@(posedge clock);
	end while (!rvalid);
	data = rdata;
	resp = rresp;
endtask

task automatic axi_write(addr_t address, data_t data, output resp_t resp);
	send_write(address, data);
	wait_write_response(resp);
endtask

task automatic axi_read(addr_t address, output data_t data, output resp_t resp);
	send_read(address);
	wait_read_response(data, resp);
endtask

// Plain accesses that must answer OKAY
task automatic write_word(addr_t address, data_t data);
	resp_t resp;
	axi_write(address, data, resp);
	check_resp("o_bresp", resp, RESP_OKAY);
endtask

task automatic read_word(addr_t address, output data_t data);
	resp_t resp;
	axi_read(address, data, resp);
	check_resp("o_rresp", resp, RESP_OKAY);
endtask

task automatic read_word_expect(addr_t address, data_t expected);
	data_t data;
	read_word(address, data);
	check_data("o_rdata", data, expected);
endtask

`endif

// ==== tb_soc.sv ====
`timescale 1ns/1ns

module tb_soc import soc_pkg::*; ();

	localparam int RAM_WORDS = 4096;
	localparam int RAM_LATENCY = 2;
	localparam int TICK_DIVIDER = 4;
	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 2000;

	localparam addr_t RAM_BASE = 32'h1000_0000;
	localparam addr_t DMA_BASE = 32'h9000_0000;
	localparam addr_t TIMER_BASE = 32'hA000_0000;
	localparam addr_t UNMAPPED_ADDRESS = 32'h5000_0040;

	logic  clock;
	logic  reset;
	logic  awvalid;
	logic  awready;
	addr_t awaddr;
	logic  wvalid;
	logic  wready;
	data_t wdata;
	logic  bvalid;
	logic  bready;
	resp_t bresp;
	logic  arvalid;
	logic  arready;
	addr_t araddr;
	logic  rvalid;
	logic  rready;
	data_t rdata;
	resp_t rresp;
	logic  timer_interrupt;

	data_t lcg_state = 32'd16;

	// Words written by the RAM test and reused later
	data_t ram_words [16];

	`include "tb_soc_checks.svh"

	soc #(
		.RAM_WORDS(RAM_WORDS),
		.RAM_LATENCY(RAM_LATENCY),
		.TICK_DIVIDER(TICK_DIVIDER)
	) i_soc(
		.i_clock(clock),
		.i_reset(reset),
		.i_awvalid(awvalid),
		.o_awready(awready),
		.i_awaddr(awaddr),
		.i_wvalid(wvalid),
		.o_wready(wready),
		.i_wdata(wdata),
		.o_bvalid(bvalid),
		.i_bready(bready),
		.o_bresp(bresp),
		.i_arvalid(arvalid),
		.o_arready(arready),
		.i_araddr(araddr),
		.o_rvalid(rvalid),
		.i_rready(rready),
		.o_rdata(rdata),
		.o_rresp(rresp),
		.o_timer_interrupt(timer_interrupt)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// Watchdog
	initial begin
		repeat (RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d cycles",
			RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST);
		report_failure();
	end

	//==================================================
	// DMA helpers

	task automatic start_dma(addr_t source, addr_t dest, data_t count);
		write_word(reg_address(DMA_BASE, DMA_SOURCE), source);
		write_word(reg_address(DMA_BASE, DMA_DEST), dest);
		write_word(reg_address(DMA_BASE, DMA_COUNT), count);
	endtask

	task automatic wait_dma_idle();
		data_t status;
		do begin
			read_word(reg_address(DMA_BASE, DMA_STATUS), status);
		end while (status[0]);
	endtask

	//==================================================
	// Directed tests

	task automatic ram_readback();
		for (int i = 0; i < 16; i++) begin
			ram_words[i] = next_random();
			write_word(RAM_BASE + 32'(i * 16), ram_words[i]);
		end
		for (int i = 0; i < 16; i++)
			read_word_expect(RAM_BASE + 32'(i * 16), ram_words[i]);
	endtask

	task automatic decode_error();
		data_t data;
		resp_t resp;
		axi_write(UNMAPPED_ADDRESS, 32'hDEAD_BEEF, resp);
		check_resp("o_bresp", resp, RESP_DECERR);
		axi_read(UNMAPPED_ADDRESS, data, resp);
		check_resp("o_rresp", resp, RESP_DECERR);
		check_data("o_rdata", data, 32'd0);
		// Same offset as the unmapped write
		read_word_expect(RAM_BASE + 32'(4 * 16), ram_words[4]);
	endtask

	task automatic dma_copy();
		addr_t source;
		addr_t dest;
		data_t words [8];
		data_t marker;
		source = RAM_BASE + 32'h0100;
		dest = RAM_BASE + 32'h0200;
		marker = next_random();
		// Idle after reset
		read_word_expect(reg_address(DMA_BASE, DMA_STATUS), 32'd0);
		write_word(dest + 32'd32, marker);
		for (int i = 0; i < 8; i++) begin
			words[i] = next_random();
			write_word(source + 32'(i * 4), words[i]);
		end
		start_dma(source, dest, 32'd8);
		wait_dma_idle();
		for (int i = 0; i < 8; i++)
			read_word_expect(dest + 32'(i * 4), words[i]);
		read_word_expect(dest + 32'd32, marker);
	endtask

	task automatic dma_copy_with_traffic();
		addr_t source;
		addr_t dest;
		addr_t other;
		data_t words [32];
		data_t other_words [8];
		source = RAM_BASE + 32'h0400;
		dest = RAM_BASE + 32'h0600;
		other = RAM_BASE + 32'h0800;
		for (int i = 0; i < 32; i++) begin
			words[i] = next_random();
			write_word(source + 32'(i * 4), words[i]);
		end
		for (int i = 0; i < 8; i++) begin
			other_words[i] = next_random();
			write_word(other + 32'(i * 4), other_words[i]);
		end
		start_dma(source, dest, 32'd32);
		// Outside reads compete with the running copy
		for (int i = 0; i < 8; i++)
			read_word_expect(other + 32'(i * 4), other_words[i]);
		wait_dma_idle();
		for (int i = 0; i < 32; i++)
			read_word_expect(dest + 32'(i * 4), words[i]);
	endtask

	task automatic timer_compare();
		data_t count;
		int cycles;
		read_word_expect(reg_address(TIMER_BASE, TIMER_COUNT), 32'd0);
		check_flag("o_timer_interrupt", timer_interrupt, 1'b0);
		write_word(reg_address(TIMER_BASE, TIMER_COUNT), 32'd0);
		write_word(reg_address(TIMER_BASE, TIMER_COMPARE), 32'd20);
		write_word(reg_address(TIMER_BASE, TIMER_CONTROL), 32'd1);
		cycles = 0;
		while (!timer_interrupt) begin
			@(posedge clock);
			cycles++;
			if (cycles > 30 * TICK_DIVIDER) begin
				$display("Timer interrupt did not rise within %0d cycles", 30 * TICK_DIVIDER);
				report_failure();
			end
		end
		read_word(reg_address(TIMER_BASE, TIMER_COUNT), count);
		if (count < 32'd20) begin
			$display("[ERROR] o_rdata: timer count 0x%08h, expected at least 0x%08h",
				count, 32'd20);
			report_failure();
		end
		write_word(reg_address(TIMER_BASE, TIMER_COMPARE), 32'hFFFF_FFFF);
		check_flag("o_timer_interrupt", timer_interrupt, 1'b0);
	endtask

	task automatic response_back_pressure();
		addr_t address;
		data_t value;
		data_t held_data;
		resp_t held_resp;
		address = RAM_BASE + 32'h0A00;
		value = next_random();
		@(negedge clock);
		bready = 1'b0;
		rready = 1'b0;
		send_write(address, value);
		wait_write_response(held_resp);
		check_resp("o_bresp", held_resp, RESP_OKAY);
		// A read waits behind the held write response
		@(negedge clock);
		arvalid = 1'b1;
		araddr = address;
		repeat (10) begin
			@(posedge clock);
			check_flag("o_bvalid", bvalid, 1'b1);
			check_resp("o_bresp", bresp, held_resp);
			check_flag("o_arready", arready, 1'b0);
		end
		@(negedge clock);
		bready = 1'b1;
		send_read(address);
		wait_read_response(held_data, held_resp);
		check_data("o_rdata", held_data, value);
		check_resp("o_rresp", held_resp, RESP_OKAY);
		// A write waits behind the held read response
		@(negedge clock);
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = address;
		wdata = ~value;
		repeat (10) begin
			@(posedge clock);
			check_flag("o_rvalid", rvalid, 1'b1);
			check_data("o_rdata", rdata, held_data);
			check_resp("o_rresp", rresp, held_resp);
			check_flag("o_awready", awready, 1'b0);
			check_flag("o_wready", wready, 1'b0);
		end
		@(negedge clock);
		rready = 1'b1;
		send_write(address, ~value);
		wait_write_response(held_resp);
		check_resp("o_bresp", held_resp, RESP_OKAY);
		read_word_expect(address, ~value);
	endtask

	//==================================================
	// Main sequence

	initial begin
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_flag("o_bvalid", bvalid, 1'b0);
		check_flag("o_rvalid", rvalid, 1'b0);

		ram_readback();
		decode_error();
		dma_copy();
		dma_copy_with_traffic();
		timer_compare();
		response_back_pressure();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
soc_pkg.sv
soc_bus_if.sv
bus_access.sv
bram.sv
dma.sv
timer.sv
soc.sv
tb_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_soc
FILE_LIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
